/* crypt3_sha1.f */
+incdir+bench
src/crypt3_pkg.sv
src/crypt3_issue_ctrl.sv
src/sha1_round.sv
src/sha1_round_stage.sv
src/crypt3_sha1.sv
bench/crypt3_sha1_chk.sv
bench/crypt3_sha1_tb.sv

/* Makefile */
# Verilator build and run of the sha1 hash-update testbench
TOP := crypt3_sha1_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f crypt3_sha1.f

# exit status of the simulation is the test result
run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f crypt3_sha1.f

clean:
	rm -rf obj_dir

/* bench/crypt3_sha1_model.svh */
`ifndef CRYPT3_SHA1_MODEL_SVH
`define CRYPT3_SHA1_MODEL_SVH

// reference sha1 rounds, straight from the fips 180 round definitions
// included inside the testbench module after the package import

// left rotate of one 32-bit word
function automatic word_t rotl32(input word_t x, input int n);
  rotl32 = (x << n) | (x >> (32 - n));
endfunction

// ch, parity or maj of b, c, d
function automatic word_t sha1_boolean(input sha1_op_e op, input word_t b,
                                       input word_t c, input word_t d);
  case (op)
    op_choose:   sha1_boolean = (b & c) | (~b & d);
    op_parity:   sha1_boolean = b ^ c ^ d;
    op_majority: sha1_boolean = (b & c) | (b & d) | (c & d);
    default:     sha1_boolean = '0;
  endcase
endfunction

// four rounds, abcd with a in the top word, w+k of round i in word i
function automatic quad_t sha1_four_rounds(input sha1_op_e op, input quad_t abcd,
                                           input word_t e_in, input quad_t wk);
  word_t a;
  word_t b;
  word_t c;
  word_t d;
  word_t e;
  word_t t;
  int    i;
  a = abcd[127:96];
  b = abcd[95:64];
  c = abcd[63:32];
  d = abcd[31:0];
  e = e_in;
  for (i = 0; i < 4; i++) begin
    t = rotl32(a, 5) + sha1_boolean(op, b, c, d) + e + wk[32*i +: 32];
    e = d;
    d = c;
    c = rotl32(b, 30);
    b = a;
    a = t;
  end
  // a flushed slot comes out as all zeros
  if (op == op_none) begin
    sha1_four_rounds = '0;
  end else begin
    sha1_four_rounds = {a, b, c, d};
  end
endfunction

`endif

/* bench/crypt3_sha1_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module crypt3_sha1_tb;

  import crypt3_pkg::*;

  `include "crypt3_sha1_model.svh"

  localparam int PERIOD        = 40;
  localparam int TEST_COUNT    = 14;
  localparam int MARGIN_CYCLES = 50;

  logic   ck_gclkcx_crypt;
  logic   cx_reset3;
  logic   ival_e1;
  logic   sha1c_e1;
  logic   sha1p_e1;
  logic   sha1m_e1;
  quad_t  qn_e1;
  quad_t  qm_e1;
  logic   ival_e2;
  quad_t  qd_e2;
  quad_t  crypt3_out_e6;
  logic   crypt3_active;

  integer seed = 32'h184ec08a;
  int     fail_count = 0;
  // e6 value the output should be holding
  quad_t  last_result;

  crypt3_sha1 u_dut (
    .ck_gclkcx_crypt (ck_gclkcx_crypt),
    .cx_reset3       (cx_reset3),
    .ival_e1         (ival_e1),
    .sha1c_e1        (sha1c_e1),
    .sha1p_e1        (sha1p_e1),
    .sha1m_e1        (sha1m_e1),
    .qn_e1           (qn_e1),
    .qm_e1           (qm_e1),
    .ival_e2         (ival_e2),
    .qd_e2           (qd_e2),
    .crypt3_out_e6   (crypt3_out_e6),
    .crypt3_active   (crypt3_active)
  );

  always #(PERIOD / 2) ck_gclkcx_crypt = ~ck_gclkcx_crypt;

  // ------------------------------
  // helpers
  // ------------------------------

  function automatic quad_t rand_quad();
    rand_quad = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // rotates through the three ops
  function automatic sha1_op_e pick_op(input int k);
    case (k % 3)
      0:       pick_op = op_choose;
      1:       pick_op = op_parity;
      default: pick_op = op_majority;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      fail_count++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // inputs change on the falling edge only
  task automatic next_cycle();
    @(negedge ck_gclkcx_crypt);
  endtask

  task automatic idle_inputs();
    ival_e1  = 1'b0;
    sha1c_e1 = 1'b0;
    sha1p_e1 = 1'b0;
    sha1m_e1 = 1'b0;
    ival_e2  = 1'b0;
  endtask

  task automatic drive_first(input sha1_op_e op, input quad_t qn, input quad_t qm);
    ival_e1  = 1'b1;
    sha1c_e1 = (op == op_choose);
    sha1p_e1 = (op == op_parity);
    sha1m_e1 = (op == op_majority);
    qn_e1    = qn;
    qm_e1    = qm;
  endtask

  task automatic drive_second(input quad_t qd);
    ival_e2 = 1'b1;
    qd_e2   = qd;
  endtask

  // e2 issued this cycle, result lands 4 edges later
  task automatic finish_issue(input quad_t exp);
    next_cycle();
    idle_inputs();
    repeat (3) next_cycle();
    check_value("crypt3_out_e6", crypt3_out_e6, exp);
    last_result = exp;
  endtask

  // first uop, gap idle cycles with junk on the data lines, second uop
  task automatic issue_pair(input sha1_op_e op, input int gap);
    quad_t qn;
    quad_t qm;
    quad_t qd;
    qn = rand_quad();
    qm = rand_quad();
    qd = rand_quad();
    next_cycle();
    drive_first(op, qn, qm);
    repeat (gap) begin
      next_cycle();
      idle_inputs();
      qn_e1 = rand_quad();
      qm_e1 = rand_quad();
      qd_e2 = rand_quad();
      check_value("crypt3_out_e6 hold", crypt3_out_e6, last_result);
    end
    next_cycle();
    drive_second(qd);
    finish_issue(sha1_four_rounds(op, qd, qn[31:0], qm));
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic test_single_ops();
    int k;
    for (k = 0; k < 3; k++) begin
      issue_pair(pick_op(k), 2);
    end
  endtask

  // gaps of 1, 3, 5 and 7 idle cycles
  task automatic test_delayed_second();
    int k;
    for (k = 0; k < 4; k++) begin
      issue_pair(pick_op(k + 2), 2 * k + 1);
    end
  endtask

  task automatic test_back_to_back();
    quad_t    qn;
    quad_t    qm;
    quad_t    qd;
    quad_t    exp_q [4];
    sha1_op_e op;
    int       k;
    for (k = 0; k < 4; k++) begin
      op = pick_op(k);
      qn = rand_quad();
      qm = rand_quad();
      qd = rand_quad();
      next_cycle();
      drive_first(op, qn, qm);
      drive_second(qd);
      exp_q[k] = sha1_four_rounds(op, qd, qn[31:0], qm);
    end
    // one result per cycle, N+4 to N+7
    for (k = 0; k < 4; k++) begin
      next_cycle();
      idle_inputs();
      check_value("crypt3_out_e6", crypt3_out_e6, exp_q[k]);
    end
    last_result = exp_q[3];
  endtask

  // second uop with nothing pending
  task automatic test_flush();
    next_cycle();
    drive_second(rand_quad());
    finish_issue('0);
  endtask

  task automatic test_active_level();
    quad_t qn;
    quad_t qm;
    quad_t qd;
    int    k;
    qn = rand_quad();
    qm = rand_quad();
    qd = rand_quad();
    repeat (2) begin
      next_cycle();
      #1;
      check_value("crypt3_active idle", 128'(crypt3_active), '0);
    end
    next_cycle();
    drive_first(op_parity, qn, qm);
    #1;
    check_value("crypt3_active e1", 128'(crypt3_active), 128'(1));
    next_cycle();
    idle_inputs();
    drive_second(qd);
    #1;
    check_value("crypt3_active e2", 128'(crypt3_active), 128'(1));
    // stages 1 to 3 in flight
    for (k = 1; k <= 3; k++) begin
      next_cycle();
      idle_inputs();
      #1;
      check_value("crypt3_active flight", 128'(crypt3_active), 128'(1));
    end
    // result stage does not count
    next_cycle();
    #1;
    check_value("crypt3_active e6", 128'(crypt3_active), '0);
    last_result = sha1_four_rounds(op_parity, qd, qn[31:0], qm);
    check_value("crypt3_out_e6", crypt3_out_e6, last_result);
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    ck_gclkcx_crypt = 1'b0;
    cx_reset3       = 1'b1;
    idle_inputs();
    qn_e1 = '0;
    qm_e1 = '0;
    qd_e2 = '0;
    repeat (3) @(posedge ck_gclkcx_crypt);
    next_cycle();
    cx_reset3 = 1'b0;
    #1;
    check_value("crypt3_active reset", 128'(crypt3_active), '0);
    test_flush();
    test_active_level();
    test_single_ops();
    test_delayed_second();
    test_flush();
    test_back_to_back();
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "checks failed");
    end
  end

  // bound on instruction count, about 12 cycles each
  initial begin
    #((TEST_COUNT * 12 + MARGIN_CYCLES) * PERIOD);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

/* bench/crypt3_sha1_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// issue control properties
module crypt3_sha1_chk (
  input wire                                 ck_gclkcx_crypt,
  input wire                                 cx_reset3,
  input wire                                 ival_e1,
  input wire                                 sha1c_e1,
  input wire                                 sha1p_e1,
  input wire                                 sha1m_e1,
  input wire                                 ival_e2,
  input wire                                 crypt3_active,
  input wire                                 pending_q
);

  // selects are one-hot or empty
  one_select: assert property (@(posedge ck_gclkcx_crypt) disable iff (cx_reset3)
    ival_e1 |-> $onehot0({sha1c_e1, sha1p_e1, sha1m_e1}))
    else $error("more than one sha1 select with ival_e1");

  // clock gate stays open from e2 until the slot leaves stage 3
  active_cover: assert property (@(posedge ck_gclkcx_crypt) disable iff (cx_reset3)
    (ival_e2 || $past(ival_e2) || $past(ival_e2, 2) || $past(ival_e2, 3))
      |-> crypt3_active)
    else $error("crypt3_active low with work in flight");

  // nothing pending out of reset
  pending_clear: assert property (@(posedge ck_gclkcx_crypt)
    $fell(cx_reset3) |-> !pending_q)
    else $error("pending flag set right after reset");

endmodule

bind crypt3_issue_ctrl crypt3_sha1_chk u_chk (
  .ck_gclkcx_crypt (ck_gclkcx_crypt),
  .cx_reset3       (cx_reset3),
  .ival_e1         (ival_e1),
  .sha1c_e1        (sha1c_e1),
  .sha1p_e1        (sha1p_e1),
  .sha1m_e1        (sha1m_e1),
  .ival_e2         (ival_e2),
  .crypt3_active   (crypt3_active),
  .pending_q       (pending_q)
);

`default_nettype wire

/* src/crypt3_sha1.sv */
`timescale 1ns/1ps
`default_nettype none

// sha1 hash update, choose / parity / majority
// e1 and e2 operand collection, rounds in e2 to e5, result in e6
module crypt3_sha1 (
  input  wire                ck_gclkcx_crypt,
  input  wire                cx_reset3,
  input  wire                ival_e1,
  input  wire                sha1c_e1,
  input  wire                sha1p_e1,
  input  wire                sha1m_e1,
  input  crypt3_pkg::quad_t  qn_e1,
  input  crypt3_pkg::quad_t  qm_e1,
  input  wire                ival_e2,
  input  crypt3_pkg::quad_t  qd_e2,
  output crypt3_pkg::quad_t  crypt3_out_e6,
  output logic               crypt3_active
);

  import crypt3_pkg::*;

  // index 0 from the issue control, index i from stage i
  logic     v   [SHA1_ROUNDS];
  sha1_op_e op  [SHA1_ROUNDS];
  quad_t    st  [SHA1_ROUNDS];
  word_t    e   [SHA1_ROUNDS];
  quad_t    w   [SHA1_ROUNDS];

  // in-flight valids of stages 1 to 3
  logic [SHA1_ROUNDS-2:0] stage_valid;

  assign stage_valid = {v[3], v[2], v[1]};

  // ------------------------------
  // issue
  // ------------------------------

  crypt3_issue_ctrl u_issue (
    .ck_gclkcx_crypt (ck_gclkcx_crypt),
    .cx_reset3       (cx_reset3),
    .ival_e1         (ival_e1),
    .sha1c_e1        (sha1c_e1),
    .sha1p_e1        (sha1p_e1),
    .sha1m_e1        (sha1m_e1),
    .qn_e1           (qn_e1),
    .qm_e1           (qm_e1),
    .ival_e2         (ival_e2),
    .qd_e2           (qd_e2),
    .stage_valid     (stage_valid),
    .s_valid         (v[0]),
    .s_op            (op[0]),
    .s_state         (st[0]),
    .s_e             (e[0]),
    .s_w             (w[0]),
    .crypt3_active   (crypt3_active)
  );

  // ------------------------------
  // round stages
  // ------------------------------

  // stage 1, round 0 in e2
  sha1_round_stage u_stage1 (
    .ck_gclkcx_crypt (ck_gclkcx_crypt), .cx_reset3 (cx_reset3),
    .in_valid  (v[0]), .in_op  (op[0]), .in_state  (st[0]), .in_e  (e[0]), .in_w  (w[0]),
    .out_valid (v[1]), .out_op (op[1]), .out_state (st[1]), .out_e (e[1]), .out_w (w[1])
  );

  // stage 2, round 1 in e3
  sha1_round_stage u_stage2 (
    .ck_gclkcx_crypt (ck_gclkcx_crypt), .cx_reset3 (cx_reset3),
    .in_valid  (v[1]), .in_op  (op[1]), .in_state  (st[1]), .in_e  (e[1]), .in_w  (w[1]),
    .out_valid (v[2]), .out_op (op[2]), .out_state (st[2]), .out_e (e[2]), .out_w (w[2])
  );

  // stage 3, round 2 in e4
  sha1_round_stage u_stage3 (
    .ck_gclkcx_crypt (ck_gclkcx_crypt), .cx_reset3 (cx_reset3),
    .in_valid  (v[2]), .in_op  (op[2]), .in_state  (st[2]), .in_e  (e[2]), .in_w  (w[2]),
    .out_valid (v[3]), .out_op (op[3]), .out_state (st[3]), .out_e (e[3]), .out_w (w[3])
  );

  // stage 4, round 3 in e5
  // only the state leaves the unit
  sha1_round_stage u_stage4 (
    .ck_gclkcx_crypt (ck_gclkcx_crypt), .cx_reset3 (cx_reset3),
    .in_valid  (v[3]), .in_op  (op[3]), .in_state  (st[3]), .in_e  (e[3]), .in_w  (w[3]),
    .out_valid (), .out_op (), .out_state (crypt3_out_e6), .out_e (), .out_w ()
  );

endmodule

`default_nettype wire

/* src/sha1_round_stage.sv */
`timescale 1ns/1ps
`default_nettype none

// one pipeline stage
// round on the incoming state, then registers loaded on in_valid
module sha1_round_stage (
  input  wire                  ck_gclkcx_crypt,
  input  wire                  cx_reset3,
  input  wire                  in_valid,
  input  crypt3_pkg::sha1_op_e in_op,
  input  crypt3_pkg::quad_t    in_state,
  input  crypt3_pkg::word_t    in_e,
  input  crypt3_pkg::quad_t    in_w,
  output logic                 out_valid,
  output crypt3_pkg::sha1_op_e out_op,
  output crypt3_pkg::quad_t    out_state,
  output crypt3_pkg::word_t    out_e,
  output crypt3_pkg::quad_t    out_w
);

  import crypt3_pkg::*;

  quad_t rnd_state;
  word_t rnd_e;
  quad_t w_shift;

  // ------------------------------
  // round logic
  // ------------------------------

  // this stage consumes the lowest schedule word
  sha1_round u_round (
    .op        (in_op),
    .state     (in_state),
    .e         (in_e),
    .w         (in_w[WORD_W-1:0]),
    .new_state (rnd_state),
    .new_e     (rnd_e)
  );

  // next round's w+k moves into word 0
  // top word fills with zeros
  assign w_shift = {{WORD_W{1'b0}}, in_w[QUAD_WORDS*WORD_W-1:WORD_W]};

  // ------------------------------
  // stage registers
  // ------------------------------

  // valid tracks the slot every cycle
  always_ff @(posedge ck_gclkcx_crypt or posedge cx_reset3) begin
    if (cx_reset3) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // data holds between instructions
  // last stage output is the e6 result
  always_ff @(posedge ck_gclkcx_crypt) begin
    if (in_valid) begin
      out_op    <= in_op;
      out_state <= rnd_state;
      out_e     <= rnd_e;
      out_w     <= w_shift;
    end
  end

endmodule

`default_nettype wire

/* src/sha1_round.sv */
`timescale 1ns/1ps
`default_nettype none

// one sha1 round, purely combinational
// choose, parity or majority picked by op
module sha1_round (
  input  crypt3_pkg::sha1_op_e op,
  input  crypt3_pkg::quad_t    state,
  input  crypt3_pkg::word_t    e,
  input  crypt3_pkg::word_t    w,
  output crypt3_pkg::quad_t    new_state,
  output crypt3_pkg::word_t    new_e
);

  import crypt3_pkg::*;

  word_t a;
  word_t b;
  word_t c;
  word_t d;
  word_t f;
  word_t a_rol5;
  word_t b_rol30;
  word_t new_a;

  // ------------------------------
  // state unpack
  // ------------------------------

  // a sits in the top word
  assign a = state[4*WORD_W-1:3*WORD_W];
  assign b = state[3*WORD_W-1:2*WORD_W];
  assign c = state[2*WORD_W-1:1*WORD_W];
  assign d = state[1*WORD_W-1:0];

  // fixed rotates are just rewiring
  assign a_rol5  = {a[WORD_W-6:0], a[WORD_W-1:WORD_W-5]};
  assign b_rol30 = {b[1:0], b[WORD_W-1:2]};

  // ------------------------------
  // round function
  // ------------------------------

  always_comb begin
    case (op)
      // b selects between c and d
      op_choose: begin
        f = (b & c) | (~b & d);
      end
      op_parity: begin
        f = b ^ c ^ d;
      end
      // two of three
      op_majority: begin
        f = (b & c) | (b & d) | (c & d);
      end
      default: begin
        f = '0;
      end
    endcase
  end

  // modulo 2^32 adds
  assign new_a = a_rol5 + f + e + w;

  // ------------------------------
  // state shift
  // ------------------------------

  // old d drops out as the next e
  // empty slot gives zeros
  always_comb begin
    if (op == op_none) begin
      new_state = '0;
      new_e     = '0;
    end else begin
      new_state = {new_a, a, b_rol30, c};
      new_e     = d;
    end
  end

endmodule

`default_nettype wire

/* src/crypt3_issue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// operand collection for the two micro-op sha1 instruction
// first uop brings qn, qm and the select, second uop brings qd
module crypt3_issue_ctrl (
  input  wire                                 ck_gclkcx_crypt,
  input  wire                                 cx_reset3,
  input  wire                                 ival_e1,
  input  wire                                 sha1c_e1,
  input  wire                                 sha1p_e1,
  input  wire                                 sha1m_e1,
  input  crypt3_pkg::quad_t                   qn_e1,
  input  crypt3_pkg::quad_t                   qm_e1,
  input  wire                                 ival_e2,
  input  crypt3_pkg::quad_t                   qd_e2,
  input  wire [crypt3_pkg::SHA1_ROUNDS-2:0]   stage_valid,
  output logic                                s_valid,
  output crypt3_pkg::sha1_op_e                s_op,
  output crypt3_pkg::quad_t                   s_state,
  output crypt3_pkg::word_t                   s_e,
  output crypt3_pkg::quad_t                   s_w,
  output logic                                crypt3_active
);

  import crypt3_pkg::*;

  sha1_op_e enc_op;
  sha1_op_e op_q;
  word_t    e_q;
  quad_t    w_q;
  logic     pending_q;
  logic     have_first;
  sha1_op_e cur_op;
  word_t    cur_e;
  quad_t    cur_w;

  // ------------------------------
  // first uop capture
  // ------------------------------

  // one-hot selects to op code
  always_comb begin
    if (sha1c_e1) begin
      enc_op = op_choose;
    end else if (sha1p_e1) begin
      enc_op = op_parity;
    end else if (sha1m_e1) begin
      enc_op = op_majority;
    end else begin
      enc_op = op_none;
    end
  end

  // only word 0 of qn (e) is needed
  always_ff @(posedge ck_gclkcx_crypt) begin
    if (ival_e1) begin
      op_q <= enc_op;
      e_q  <= qn_e1[WORD_W-1:0];
      w_q  <= qm_e1;
    end
  end

  // pending first operand
  // set by ival_e1, held until the second uop consumes it
  // a flushed first uop leaves it low
  always_ff @(posedge ck_gclkcx_crypt or posedge cx_reset3) begin
    if (cx_reset3) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= ival_e1 | (pending_q & ~ival_e2);
    end
  end

  // ------------------------------
  // second uop issue
  // ------------------------------

  // same-cycle first uop bypasses the capture registers
  assign have_first = ival_e1 | pending_q;
  assign cur_op     = ival_e1 ? enc_op : op_q;
  assign cur_e      = ival_e1 ? qn_e1[WORD_W-1:0] : e_q;
  assign cur_w      = ival_e1 ? qm_e1 : w_q;

  assign s_valid = ival_e2;
  assign s_op    = have_first ? cur_op : op_none;

  // no valid op means all-zero operands into the rounds
  assign s_state = (s_op == op_none) ? '0 : qd_e2;
  assign s_e     = (s_op == op_none) ? '0 : cur_e;
  assign s_w     = (s_op == op_none) ? '0 : cur_w;

  // clock gating level
  // e1, e2 and the in-flight stages, output stage not counted
  assign crypt3_active = ival_e1 | ival_e2 | (|stage_valid);

endmodule

`default_nettype wire

/* src/crypt3_pkg.sv */
`default_nettype none

// shared types for the sha1 hash-update unit
package crypt3_pkg;

  // ------------------------------
  // sizes
  // ------------------------------

  // bits per sha word
  localparam int WORD_W = 32;

  // words per 128-bit quad register
  localparam int QUAD_WORDS = 4;

  // rounds per instruction, one per pipeline stage (e2 to e5)
  localparam int SHA1_ROUNDS = 4;

  // ------------------------------
  // data types
  // ------------------------------

  // one sha word
  typedef logic [WORD_W-1:0] word_t;

  // four words, word 0 in the low bits
  // hash state: a in word 3, b in 2, c in 1, d in 0
  // schedule: w+k of round i in word i
  typedef logic [QUAD_WORDS*WORD_W-1:0] quad_t;

  // ------------------------------
  // operation select
  // ------------------------------

  // op_none also marks a flushed or empty slot
  typedef enum logic [1:0] {
    op_none     = 2'd0,
    op_choose   = 2'd1,
    op_parity   = 2'd2,
    op_majority = 2'd3
  } sha1_op_e;

endpackage

`default_nettype wire
